// ==== hw/dsp_pkg.sv ====
package dsp_pkg;

    // operand and result widths
    localparam int a_w  = 30;
    localparam int b_w  = 18;
    localparam int c_w  = 48;
    localparam int d_w  = 25;
    localparam int ad_w = 25;                 // pre-adder result, wraps
    localparam int m_w  = 43;                 // signed ad_w x b_w product
    localparam int p_w  = 48;

    localparam int pipe_depth = 5;            // input to output latency in cycles

    typedef logic [a_w-1:0]  a_t;
    typedef logic [b_w-1:0]  b_t;
    typedef logic [c_w-1:0]  c_t;
    typedef logic [d_w-1:0]  d_t;
    typedef logic [ad_w-1:0] ad_t;
    typedef logic [m_w-1:0]  m_t;
    typedef logic [p_w-1:0]  p_t;

    typedef logic [2:0] inmode_t;
    typedef logic [6:0] opmode_t;             // [1:0] x, [3:2] y, [6:4] z
    typedef logic [3:0] alumode_t;

    // inmode bit positions
    localparam int inmode_gate_a = 0;
    localparam int inmode_use_d  = 1;
    localparam int inmode_neg_a  = 2;

    localparam int opmode_y_ones = 3;         // picks the second logic variant

    localparam logic [1:0] x_zero = 2'b00;
    localparam logic [1:0] x_m    = 2'b01;
    localparam logic [1:0] x_ab   = 2'b11;    // a:b concatenation
    localparam logic [1:0] y_zero = 2'b00;
    localparam logic [1:0] y_ones = 2'b10;
    localparam logic [1:0] y_c    = 2'b11;
    localparam logic [2:0] z_zero = 3'b000;
    localparam logic [2:0] z_p    = 3'b010;   // accumulate on p
    localparam logic [2:0] z_c    = 3'b011;

    localparam alumode_t alu_add      = 4'b0000;
    localparam alumode_t alu_notz_add = 4'b0001;
    localparam alumode_t alu_not_sum  = 4'b0010;
    localparam alumode_t alu_sub      = 4'b0011;
    localparam alumode_t alu_xor      = 4'b0100;
    localparam alumode_t alu_xnor     = 4'b0101;
    localparam alumode_t alu_xnor_alt = 4'b0110;
    localparam alumode_t alu_xor_alt  = 4'b0111;
    localparam alumode_t alu_and      = 4'b1100;
    localparam alumode_t alu_and_notz = 4'b1101;
    localparam alumode_t alu_nand     = 4'b1110;
    localparam alumode_t alu_notx_or  = 4'b1111;

    // all logic codes have bit 2 set, arithmetic ones never do
    function automatic logic is_logic_mode(alumode_t mode);
        return mode[2];
    endfunction

endpackage

// ==== hw/dsp_input_stage.sv ====
`timescale 1ns/100ps

module dsp_input_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  dsp_pkg::a_t        a,
    input  dsp_pkg::b_t        b,
    input  dsp_pkg::c_t        c,
    input  dsp_pkg::d_t        d,
    input  dsp_pkg::inmode_t   inmode,
    input  dsp_pkg::opmode_t   opmode,
    input  dsp_pkg::alumode_t  alumode,
    output logic               s1_valid,
    output dsp_pkg::a_t        s1_a,
    output dsp_pkg::b_t        s1_b,
    output dsp_pkg::c_t        s1_c,
    output dsp_pkg::d_t        s1_d,
    output dsp_pkg::inmode_t   s1_inmode,
    output dsp_pkg::opmode_t   s1_opmode,
    output dsp_pkg::alumode_t  s1_alumode
);

    // input register bank, one flop per port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            s1_a       <= '0;
            s1_b       <= '0;
            s1_c       <= '0;
            s1_d       <= '0;
            s1_inmode  <= '0;
            s1_opmode  <= '0;
            s1_alumode <= '0;
        end else begin
            s1_valid   <= in_valid;             // loads every cycle, no stall
            s1_a       <= a;
            s1_b       <= b;
            s1_c       <= c;
            s1_d       <= d;
            s1_inmode  <= inmode;
            s1_opmode  <= opmode;
            s1_alumode <= alumode;
        end
    end

endmodule

// ==== hw/dsp_preadder.sv ====
`timescale 1ns/100ps

module dsp_preadder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               s1_valid,
    input  dsp_pkg::a_t        s1_a,
    input  dsp_pkg::b_t        s1_b,
    input  dsp_pkg::c_t        s1_c,
    input  dsp_pkg::d_t        s1_d,
    input  dsp_pkg::inmode_t   s1_inmode,
    input  dsp_pkg::opmode_t   s1_opmode,
    input  dsp_pkg::alumode_t  s1_alumode,
    output logic               s2_valid,
    output dsp_pkg::ad_t       s2_ad,
    output dsp_pkg::a_t        s2_a,
    output dsp_pkg::b_t        s2_b,
    output dsp_pkg::c_t        s2_c,
    output dsp_pkg::opmode_t   s2_opmode,
    output dsp_pkg::alumode_t  s2_alumode
);

    import dsp_pkg::*;

    ad_t d_term;
    ad_t a_term;
    ad_t ad_sum;

    assign d_term = s1_inmode[inmode_use_d]  ? s1_d : '0;
    assign a_term = s1_inmode[inmode_gate_a] ? '0 : s1_a[ad_w-1:0];   // low bits of a only
    assign ad_sum = s1_inmode[inmode_neg_a]  ? d_term - a_term : d_term + a_term;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid   <= 1'b0;
            s2_opmode  <= '0;
            s2_alumode <= '0;
        end else begin
            s2_valid   <= s1_valid;
            s2_opmode  <= s1_opmode;
            s2_alumode <= s1_alumode;
        end
    end

    always_ff @(posedge clk) begin
        s2_ad <= ad_sum;                        // wraps to 25 bits
        s2_a  <= s1_a;                          // still needed for a:b
        s2_b  <= s1_b;
        s2_c  <= s1_c;
    end

endmodule

// ==== hw/dsp_multiplier.sv ====
`timescale 1ns/100ps

module dsp_multiplier (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               s2_valid,
    input  dsp_pkg::ad_t       s2_ad,
    input  dsp_pkg::a_t        s2_a,
    input  dsp_pkg::b_t        s2_b,
    input  dsp_pkg::c_t        s2_c,
    input  dsp_pkg::opmode_t   s2_opmode,
    input  dsp_pkg::alumode_t  s2_alumode,
    output logic               s3_valid,
    output dsp_pkg::m_t        s3_m,
    output dsp_pkg::a_t        s3_a,
    output dsp_pkg::b_t        s3_b,
    output dsp_pkg::c_t        s3_c,
    output dsp_pkg::opmode_t   s3_opmode,
    output dsp_pkg::alumode_t  s3_alumode
);

    import dsp_pkg::*;

    m_t product;

    // both operands signed, result fits 43 bits exactly
    assign product = $signed(s2_ad) * $signed(s2_b);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s3_valid   <= 1'b0;
            s3_opmode  <= '0;
            s3_alumode <= '0;
        end else begin
            s3_valid   <= s2_valid;
            s3_opmode  <= s2_opmode;
            s3_alumode <= s2_alumode;
        end
    end

    always_ff @(posedge clk) begin
        s3_m <= product;
        s3_a <= s2_a;
        s3_b <= s2_b;
        s3_c <= s2_c;
    end

endmodule

// ==== hw/dsp_alu.sv ====
`timescale 1ns/100ps

module dsp_alu (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               s3_valid,
    input  dsp_pkg::m_t        s3_m,
    input  dsp_pkg::a_t        s3_a,
    input  dsp_pkg::b_t        s3_b,
    input  dsp_pkg::c_t        s3_c,
    input  dsp_pkg::opmode_t   s3_opmode,
    input  dsp_pkg::alumode_t  s3_alumode,
    output logic               s4_valid,
    output dsp_pkg::p_t        s4_p,
    output logic               s4_carry,
    output dsp_pkg::c_t        s4_c
);

    import dsp_pkg::*;

    p_t           x_op;
    p_t           y_op;
    p_t           z_op;
    logic         y_ones_sel;
    logic [p_w:0] alu_res;                      // carry in the top bit

    always_comb begin
        case (s3_opmode[1:0])
            x_m:     x_op = {{(p_w-m_w){s3_m[m_w-1]}}, s3_m};    // sign extend product
            x_ab:    x_op = {s3_a, s3_b};
            x_zero:  x_op = '0;
            default: x_op = '0;
        endcase
        case (s3_opmode[3:2])
            y_ones:  y_op = '1;
            y_c:     y_op = s3_c;
            y_zero:  y_op = '0;
            default: y_op = '0;                 // 01 is zero, product is already whole
        endcase
        case (s3_opmode[6:4])
            z_p:     z_op = s4_p;               // last valid result
            z_c:     z_op = s3_c;
            z_zero:  z_op = '0;
            default: z_op = '0;
        endcase
    end

    assign y_ones_sel = s3_opmode[opmode_y_ones];

    always_comb begin
        alu_res = '0;
        if (is_logic_mode(s3_alumode)) begin
            case (s3_alumode)
                alu_xor, alu_xor_alt:   alu_res[p_w-1:0] = y_ones_sel ? ~(x_op ^ z_op) : x_op ^ z_op;
                alu_xnor, alu_xnor_alt: alu_res[p_w-1:0] = y_ones_sel ? x_op ^ z_op : ~(x_op ^ z_op);
                alu_and:      alu_res[p_w-1:0] = y_ones_sel ? x_op | z_op : x_op & z_op;
                alu_and_notz: alu_res[p_w-1:0] = y_ones_sel ? x_op | ~z_op : x_op & ~z_op;
                alu_nand:     alu_res[p_w-1:0] = y_ones_sel ? ~(x_op | z_op) : ~(x_op & z_op);
                alu_notx_or:  alu_res[p_w-1:0] = y_ones_sel ? ~x_op & z_op : ~x_op | z_op;
                default:      alu_res = '0;
            endcase
        end else begin
            case (s3_alumode)
                alu_add:      alu_res = {1'b0, z_op} + {1'b0, x_op} + {1'b0, y_op};
                alu_notz_add: alu_res = {1'b0, ~z_op} + {1'b0, x_op} + {1'b0, y_op};
                alu_not_sum:  alu_res = ~({1'b0, z_op} + {1'b0, x_op} + {1'b0, y_op});
                alu_sub:      alu_res = {1'b0, z_op} - ({1'b0, x_op} + {1'b0, y_op});
                default:      alu_res = '0;     // unused codes give zero
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s4_valid <= 1'b0;
            s4_p     <= '0;
            s4_carry <= 1'b0;
        end else begin
            s4_valid <= s3_valid;
            if (s3_valid) begin                 // p holds between valid items
                s4_p     <= alu_res[p_w-1:0];
                s4_carry <= alu_res[p_w];
            end
        end
    end

    always_ff @(posedge clk) begin
        s4_c <= s3_c;                           // pattern source for stage 5
    end

endmodule

// ==== hw/dsp_pattern_detect.sv ====
`timescale 1ns/100ps

module dsp_pattern_detect #(
    parameter dsp_pkg::p_t pattern        = '0,
    parameter dsp_pkg::p_t mask           = '0,  // set bits are ignored
    parameter bit          pattern_from_c = 1'b1
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         s4_valid,
    input  dsp_pkg::p_t  s4_p,
    input  logic         s4_carry,
    input  dsp_pkg::c_t  s4_c,
    output logic         out_valid,
    output dsp_pkg::p_t  p,
    output logic         carry_out,
    output logic         pattern_detect,
    output logic         pattern_b_detect,
    output logic         overflow,
    output logic         underflow
);

    import dsp_pkg::*;

    p_t   pat;
    logic match;
    logic match_b;
    logic prev_match;                           // history of the last valid item
    logic prev_match_b;

    assign pat     = pattern_from_c ? s4_c : pattern;
    assign match   = &(~(s4_p ^ pat) | mask);
    assign match_b = &(~(s4_p ^ ~pat) | mask);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid        <= 1'b0;
            p                <= '0;
            carry_out        <= 1'b0;
            pattern_detect   <= 1'b0;
            pattern_b_detect <= 1'b0;
            overflow         <= 1'b0;
            underflow        <= 1'b0;
            prev_match       <= 1'b0;
            prev_match_b     <= 1'b0;
        end else begin
            out_valid        <= s4_valid;
            p                <= s4_p;
            carry_out        <= s4_carry;
            pattern_detect   <= s4_valid & match;      // flags only for real items
            pattern_b_detect <= s4_valid & match_b;
            overflow         <= s4_valid & prev_match & ~match & ~match_b;
            underflow        <= s4_valid & prev_match_b & ~match & ~match_b;
            if (s4_valid) begin
                prev_match   <= match;
                prev_match_b <= match_b;
            end
        end
    end

endmodule

// ==== hw/dsp_slice.sv ====
`timescale 1ns/100ps

module dsp_slice #(
    parameter dsp_pkg::p_t pattern        = '0,
    parameter dsp_pkg::p_t mask           = {2'b00, {(dsp_pkg::p_w-2){1'b1}}},
    parameter bit          pattern_from_c = 1'b1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  dsp_pkg::a_t        a,
    input  dsp_pkg::b_t        b,
    input  dsp_pkg::c_t        c,
    input  dsp_pkg::d_t        d,
    input  dsp_pkg::inmode_t   inmode,
    input  dsp_pkg::opmode_t   opmode,
    input  dsp_pkg::alumode_t  alumode,
    output logic               out_valid,
    output dsp_pkg::p_t        p,
    output logic               carry_out,
    output logic               pattern_detect,
    output logic               pattern_b_detect,
    output logic               overflow,
    output logic               underflow
);

    import dsp_pkg::*;

    logic     s1_valid, s2_valid, s3_valid, s4_valid;
    a_t       s1_a, s2_a, s3_a;
    b_t       s1_b, s2_b, s3_b;
    c_t       s1_c, s2_c, s3_c, s4_c;
    d_t       s1_d;
    inmode_t  s1_inmode;
    opmode_t  s1_opmode, s2_opmode, s3_opmode;
    alumode_t s1_alumode, s2_alumode, s3_alumode;
    ad_t      s2_ad;
    m_t       s3_m;
    p_t       s4_p;
    logic     s4_carry;

    dsp_input_stage u_input (
        .clk, .rst_n, .in_valid, .a, .b, .c, .d, .inmode, .opmode, .alumode,
        .s1_valid, .s1_a, .s1_b, .s1_c, .s1_d, .s1_inmode, .s1_opmode, .s1_alumode
    );

    dsp_preadder u_preadder (
        .clk, .rst_n, .s1_valid, .s1_a, .s1_b, .s1_c, .s1_d, .s1_inmode, .s1_opmode,
        .s1_alumode, .s2_valid, .s2_ad, .s2_a, .s2_b, .s2_c, .s2_opmode, .s2_alumode
    );

    dsp_multiplier u_mult (
        .clk, .rst_n, .s2_valid, .s2_ad, .s2_a, .s2_b, .s2_c, .s2_opmode, .s2_alumode,
        .s3_valid, .s3_m, .s3_a, .s3_b, .s3_c, .s3_opmode, .s3_alumode
    );

    dsp_alu u_alu (
        .clk, .rst_n, .s3_valid, .s3_m, .s3_a, .s3_b, .s3_c, .s3_opmode, .s3_alumode,
        .s4_valid, .s4_p, .s4_carry, .s4_c
    );

    dsp_pattern_detect #(
        .pattern        (pattern),
        .mask           (mask),
        .pattern_from_c (pattern_from_c)
    ) u_patdet (
        .clk, .rst_n, .s4_valid, .s4_p, .s4_carry, .s4_c,
        .out_valid, .p, .carry_out, .pattern_detect, .pattern_b_detect,
        .overflow, .underflow
    );

endmodule

// ==== sim/dsp_slice_properties.sv ====
`timescale 1ns/100ps

module dsp_slice_properties #(
    parameter dsp_pkg::p_t mask = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  dsp_pkg::c_t        c,
    input  dsp_pkg::alumode_t  alumode,
    input  logic               out_valid,
    input  dsp_pkg::p_t        p,
    input  logic               carry_out,
    input  logic               pattern_detect,
    input  logic               overflow,
    input  logic               underflow
);

    import dsp_pkg::*;

    int fail_count = 0;                         // read by the testbench at the end

    latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, pipe_depth))
    else begin
        fail_count++;
        $error("out_valid does not follow in_valid by the pipeline depth");
    end

    flags_a: assert property (@(posedge clk) disable iff (!rst_n) !(overflow && underflow))
    else begin
        fail_count++;
        $error("overflow and underflow are both high");
    end

    // c of the same item entered pipe_depth cycles earlier
    pattern_a: assert property (@(posedge clk) disable iff (!rst_n)
        pattern_detect |-> ((p ^ $past(c, pipe_depth)) & ~mask) == '0)
    else begin
        fail_count++;
        $error("pattern_detect is high but p does not match c");
    end

    // logic codes have bit 2 set
    carry_a: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && $past(alumode[2], pipe_depth)) |-> !carry_out)
    else begin
        fail_count++;
        $error("carry_out is high after a logic mode");
    end

endmodule

bind dsp_slice dsp_slice_properties #(.mask(mask)) props (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .c(c), .alumode(alumode),
    .out_valid(out_valid), .p(p), .carry_out(carry_out),
    .pattern_detect(pattern_detect), .overflow(overflow), .underflow(underflow)
);

// ==== sim/dsp_slice_tb.sv ====
`timescale 1ns/100ps

module dsp_slice_tb;

    import dsp_pkg::*;

    localparam p_t ign_mask   = {2'b00, {(p_w-2){1'b1}}};   // default mask of the dut
    localparam int wait_limit = 50;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    a_t       a;
    b_t       b;
    c_t       c;
    d_t       d;
    inmode_t  inmode;
    opmode_t  opmode;
    alumode_t alumode;
    logic     out_valid;
    p_t       p;
    logic     carry_out;
    logic     pattern_detect;
    logic     pattern_b_detect;
    logic     overflow;
    logic     underflow;

    p_t          model_p;                       // last valid result, for z = p
    logic        prev_pd;
    logic        prev_pbd;
    logic [52:0] exp_q[$];                      // {ov, un, pbd, pd, carry, p}
    logic [52:0] exp_v;
    string       cur_test;
    int          test_items;
    int          test_errors;
    int          items_checked;
    int          total_errors;
    int          tests_run;
    integer      seed;
    a_t          ra;
    b_t          rb;
    c_t          rc;
    d_t          rd;

    dsp_slice uut (
        .clk, .rst_n, .in_valid, .a, .b, .c, .d, .inmode, .opmode, .alumode,
        .out_valid, .p, .carry_out, .pattern_detect, .pattern_b_detect,
        .overflow, .underflow
    );

    always #4 clk = ~clk;

    function automatic logic [48:0] ref_result(input a_t a_v, input b_t b_v, input c_t c_v,
            input d_t d_v, input inmode_t im, input opmode_t om, input alumode_t am,
            input p_t prev);
        logic [24:0] dterm;
        logic [24:0] aterm;
        logic [24:0] ad;
        longint      prod;
        logic [47:0] xv;
        logic [47:0] yv;
        logic [47:0] zv;
        logic [48:0] s;
        dterm = im[1] ? d_v : 25'd0;
        aterm = im[0] ? 25'd0 : a_v[24:0];
        ad    = im[2] ? dterm - aterm : dterm + aterm;
        prod  = $signed(ad) * $signed(b_v);
        xv = (om[1:0] == 2'b01) ? prod[47:0] : (om[1:0] == 2'b11) ? {a_v, b_v} : 48'd0;
        yv = (om[3:2] == 2'b10) ? '1 : (om[3:2] == 2'b11) ? c_v : 48'd0;
        zv = (om[6:4] == 3'b010) ? prev : (om[6:4] == 3'b011) ? c_v : 48'd0;
        case (am)
            4'b0000: s = {1'b0, zv} + xv + yv;
            4'b0001: s = {1'b0, ~zv} + xv + yv;
            4'b0010: s = ~({1'b0, zv} + xv + yv);
            4'b0011: s = {1'b0, zv} - xv - yv;
            4'b0100, 4'b0111: s = {1'b0, om[3] ? xv ~^ zv : xv ^ zv};
            4'b0101, 4'b0110: s = {1'b0, om[3] ? xv ^ zv : xv ~^ zv};
            4'b1100: s = {1'b0, om[3] ? xv | zv : xv & zv};
            4'b1101: s = {1'b0, om[3] ? xv | ~zv : xv & ~zv};
            4'b1110: s = {1'b0, om[3] ? ~(xv | zv) : ~(xv & zv)};
            4'b1111: s = {1'b0, om[3] ? ~xv & zv : ~xv | zv};
            default: s = '0;
        endcase
        return s;
    endfunction

    task automatic pick_operands();
        ra = a_t'($random(seed));
        rb = b_t'($random(seed));
        rc = c_t'({$random(seed), $random(seed)});
        rd = d_t'($random(seed));
    endtask

    // queue the expected outputs, then present the item on the next edge
    task automatic send(input a_t a_v, input b_t b_v, input c_t c_v, input d_t d_v,
            input inmode_t im, input opmode_t om, input alumode_t am);
        logic [48:0] r;
        logic        pd;
        logic        pbd;
        r   = ref_result(a_v, b_v, c_v, d_v, im, om, am, model_p);
        pd  = ((r[47:0] ^ c_v) & ~ign_mask) == '0;
        pbd = ((r[47:0] ^ ~c_v) & ~ign_mask) == '0;
        exp_q.push_back({prev_pd & ~pd & ~pbd, prev_pbd & ~pd & ~pbd, pbd, pd, r});
        model_p  = r[47:0];
        prev_pd  = pd;
        prev_pbd = pbd;
        @(posedge clk);
        in_valid <= 1'b1;
        a        <= a_v;
        b        <= b_v;
        c        <= c_v;
        d        <= d_v;
        inmode   <= im;
        opmode   <= om;
        alumode  <= am;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout while waiting for %s in test %s", what, cur_test);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (exp_q.size() != 0 && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
            abort_run("outstanding results");
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_items  = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("test %-10s items %0d errors %0d", cur_test, test_items, test_errors);
        total_errors += test_errors;
        tests_run++;
    endtask

    // outputs sampled half a cycle after they change
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("%s: an output appeared with no item in flight", cur_test);
                test_errors++;
            end else begin
                exp_v = exp_q.pop_front();
                test_items++;
                items_checked++;
                assert ({overflow, underflow, pattern_b_detect, pattern_detect, carry_out, p}
                        == exp_v)
                else begin
                    $display("Error: %s expected %h actual %h", cur_test, exp_v,
                             {overflow, underflow, pattern_b_detect, pattern_detect,
                              carry_out, p});
                    test_errors++;
                end
            end
        end
    end

    initial begin
        int          i;
        int          cycles;
        logic [48:0] res;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        a = '0;
        b = '0;
        c = '0;
        d = '0;
        inmode = '0;
        opmode = '0;
        alumode = '0;
        model_p = '0;
        prev_pd = 1'b0;
        prev_pbd = 1'b0;
        items_checked = 0;
        total_errors = 0;
        tests_run = 0;
        seed = 32'hfb39_d788;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        begin_test("reset");
        @(negedge clk);
        assert (!out_valid && p == '0 && !carry_out && !pattern_detect && !pattern_b_detect
                && !overflow && !underflow)
        else begin
            $display("reset: outputs are not cleared after reset");
            test_errors++;
        end
        repeat (2) begin
            pick_operands();
            send(ra, rb, rc, rd, 3'b010, 7'b000_00_01, 4'b0000);
            idle(1);                            // the item is taken on this edge
            cycles = 0;
            while (!out_valid && cycles < wait_limit) begin
                @(negedge clk);
                cycles++;
            end
            if (!out_valid)
                abort_run("out_valid");
            assert (cycles == pipe_depth)
            else begin
                $display("Error: %s expected %0d actual %0d", cur_test, pipe_depth, cycles);
                test_errors++;
            end
            drain();
        end
        end_test();

        begin_test("multiply");
        for (i = 0; i < 8; i++) begin
            pick_operands();
            send(ra, rb, rc, rd, inmode_t'(i), 7'b000_00_01, 4'b0000);
        end
        drain();
        end_test();

        begin_test("arith");
        for (i = 0; i < 8; i++) begin
            pick_operands();
            send(ra, rb, rc, rd, 3'b000, {3'b011, i[2] ? 2'b11 : 2'b00, 2'b11},
                 alumode_t'(i[1:0]));
        end
        drain();
        end_test();

        begin_test("logic");
        for (i = 0; i < 16; i++) begin
            pick_operands();
            send(ra, rb, rc, rd, 3'b000, {3'b011, i[3] ? 2'b10 : 2'b00, 2'b11},
                 {i[2], 1'b1, i[1:0]});
        end
        drain();
        end_test();

        begin_test("accumulate");
        for (i = 0; i < 5; i++) begin
            if (i == 4)
                idle(3);                        // gap before the last item
            pick_operands();
            send(ra, rb, rc, rd, 3'b010, 7'b010_00_01, 4'b0000);
        end
        drain();
        end_test();

        begin_test("pattern");
        for (i = 0; i < 4; i++) begin
            pick_operands();
            res = ref_result(ra, rb, rc, rd, 3'b010, 7'b000_00_01, 4'b0000, model_p);
            case (i)
                0:       rc = res[47:0];
                2:       rc = ~res[47:0];
                default: rc = res[47:0] ^ {2'b01, rc[45:0]};   // top bits match neither
            endcase
            send(ra, rb, rc, rd, 3'b010, 7'b000_00_01, 4'b0000);
        end
        drain();
        end_test();

        total_errors += uut.props.fail_count;
        $display("tests %0d, items checked %0d, errors %0d", tests_run, items_checked,
                 total_errors);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== dsp_slice.f ====
hw/dsp_pkg.sv
hw/dsp_input_stage.sv
hw/dsp_preadder.sv
hw/dsp_multiplier.sv
hw/dsp_alu.sv
hw/dsp_pattern_detect.sv
hw/dsp_slice.sv
sim/dsp_slice_properties.sv
sim/dsp_slice_tb.sv

// ==== Bender.yml ====
package:
  name: dsp_slice

sources:
  - files:
      - hw/dsp_pkg.sv
      - hw/dsp_input_stage.sv
      - hw/dsp_preadder.sv
      - hw/dsp_multiplier.sv
      - hw/dsp_alu.sv
      - hw/dsp_pattern_detect.sv
      - hw/dsp_slice.sv
  - target: simulation
    files:
      - sim/dsp_slice_properties.sv
      - sim/dsp_slice_tb.sv
